//--- source/tcdm_pkg.sv
/*
 * tcdm package
 * data and address widths, address field positions and the
 * arbitration policy encoding shared by the data memory subsystem
 */

`default_nettype none

package tcdm_pkg;

  localparam int unsigned ADDR_W = 12;         // byte address
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8; // one enable per byte

  // address bit marking an atomic test-and-set
  localparam int unsigned TS_BIT = 10;

  typedef enum logic {
    POLICY_FIXED = 1'b0, // lowest core index wins
    POLICY_RR    = 1'b1  // core after last winner goes first
  } policy_t;

endpackage

`default_nettype wire

//--- source/tcdm_arb_ctrl.sv
/*
 * arbitration control
 * holds the crossbar arbitration policy, written through a plain
 * strobe, and counts cycles in which any bank saw a conflict
 */

`timescale 1ns/1ps
`default_nettype none

module tcdm_arb_ctrl #(
  parameter int unsigned N_BANK = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    cfg_we_i,
  input  tcdm_pkg::policy_t       cfg_policy_i,
  input  logic [N_BANK-1:0]       conflict_i,
  output tcdm_pkg::policy_t       policy_o,
  output logic [15:0]             conflict_cnt_o
);

  tcdm_pkg::policy_t policy_q;
  logic [15:0]       cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      policy_q <= tcdm_pkg::POLICY_FIXED;
      cnt_q    <= '0;
    end else begin
      if (cfg_we_i) policy_q <= cfg_policy_i; // used from next cycle on
      if (|conflict_i && cnt_q != '1) begin
        cnt_q <= cnt_q + 16'd1; // saturates at all ones
      end
    end
  end

  assign policy_o       = policy_q;
  assign conflict_cnt_o = cnt_q;

  // counter only moves up between resets
  a_cnt_monotonic: assert property (@(posedge clk_i) disable iff (!rst_ni)
    conflict_cnt_o >= $past(conflict_cnt_o));

endmodule

`default_nettype wire

//--- source/bank_arbiter.sv
/*
 * bank arbiter
 * picks one requesting core per cycle, by fixed priority or
 * round-robin after the last winner, and muxes out its payload
 */

`timescale 1ns/1ps
`default_nettype none

module bank_arbiter #(
  parameter int unsigned N_CORE = 4,
  parameter type payload_t = logic,
  localparam int unsigned IDX_W = (N_CORE > 1) ? $clog2(N_CORE) : 1
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  tcdm_pkg::policy_t         policy_i,
  input  logic     [N_CORE-1:0]     req_i,
  input  payload_t [N_CORE-1:0]     payload_i,
  output logic     [N_CORE-1:0]     gnt_o,
  output logic                      valid_o,
  output logic     [IDX_W-1:0]      winner_o,
  output payload_t                  payload_o,
  output logic                      conflict_o
);

  logic [IDX_W-1:0] rr_q; // last winner
  logic [IDX_W-1:0] winner;

  always_comb begin : pick
    int unsigned idx;
    logic        hit;
    hit    = 1'b0;
    winner = '0;
    for (int unsigned i = 0; i < N_CORE; i++) begin
      if (policy_i == tcdm_pkg::POLICY_RR) begin
        idx = rr_q + i + 1;
        idx = idx % N_CORE; // wraps past the top core
      end else begin
        idx = i;
      end
      if (!hit && req_i[idx]) begin
        hit    = 1'b1;
        winner = IDX_W'(idx);
      end
    end
  end

  always_comb begin
    gnt_o = '0;
    if (valid_o) gnt_o[winner] = 1'b1;
  end

  assign valid_o    = |req_i;
  assign winner_o   = winner;
  assign payload_o  = payload_i[winner];
  assign conflict_o = (req_i & (req_i - 1'b1)) != '0; // two or more bits set

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (valid_o) begin
      rr_q <= winner; // moves only on a grant
    end
  end

  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(gnt_o));

  a_gnt_to_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (gnt_o & ~req_i) == '0);

endmodule

`default_nettype wire

//--- source/tcdm_xbar.sv
/*
 * logarithmic crossbar
 * decodes the bank of every core request, arbitrates per bank and
 * routes the registered bank read data back to the winning core
 */

`timescale 1ns/1ps
`default_nettype none

module tcdm_xbar #(
  parameter int unsigned N_CORE     = 4,
  parameter int unsigned N_BANK     = 4,
  parameter int unsigned BANK_WORDS = 64,
  localparam int unsigned ROW_W     = $clog2(BANK_WORDS)
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  tcdm_pkg::policy_t                        policy_i,
  output logic [N_BANK-1:0]                        conflict_o,
  // core side
  input  logic [N_CORE-1:0]                        core_req_i,
  input  logic [N_CORE-1:0]                        core_wen_i,
  input  logic [N_CORE-1:0][tcdm_pkg::ADDR_W-1:0]  core_addr_i,
  input  logic [N_CORE-1:0][tcdm_pkg::BE_W-1:0]    core_be_i,
  input  logic [N_CORE-1:0][tcdm_pkg::DATA_W-1:0]  core_wdata_i,
  output logic [N_CORE-1:0]                        core_gnt_o,
  output logic [N_CORE-1:0]                        core_r_valid_o,
  output logic [N_CORE-1:0][tcdm_pkg::DATA_W-1:0]  core_r_rdata_o,
  // bank side
  output logic [N_BANK-1:0]                        bank_req_o,
  output logic [N_BANK-1:0]                        bank_wen_o,
  output logic [N_BANK-1:0]                        bank_ts_o,
  output logic [N_BANK-1:0][ROW_W-1:0]             bank_row_o,
  output logic [N_BANK-1:0][tcdm_pkg::BE_W-1:0]    bank_be_o,
  output logic [N_BANK-1:0][tcdm_pkg::DATA_W-1:0]  bank_wdata_o,
  input  logic [N_BANK-1:0][tcdm_pkg::DATA_W-1:0]  bank_rdata_i
);

  localparam int unsigned BANK_IW   = (N_BANK > 1) ? $clog2(N_BANK) : 1;
  localparam int unsigned IDX_W     = (N_CORE > 1) ? $clog2(N_CORE) : 1;
  localparam int unsigned ROW_LSB   = 2 + $clog2(N_BANK); // above offset and bank bits
  localparam int unsigned PAYLOAD_W = 2 + ROW_W + tcdm_pkg::BE_W + tcdm_pkg::DATA_W;

  // wen, ts, row, be, wdata packed flat
  typedef logic [PAYLOAD_W-1:0] req_payload_t;

  logic         [N_CORE-1:0][BANK_IW-1:0] bank_sel;
  req_payload_t [N_CORE-1:0]              core_payload;
  logic         [N_BANK-1:0][N_CORE-1:0]  bank_core_req;
  logic         [N_BANK-1:0][N_CORE-1:0]  bank_gnt;
  logic         [N_BANK-1:0][IDX_W-1:0]   bank_winner;
  req_payload_t [N_BANK-1:0]              bank_payload;
  logic         [N_BANK-1:0]              resp_valid_q;
  logic         [N_BANK-1:0][IDX_W-1:0]   resp_core_q;

  for (genvar c = 0; c < N_CORE; c++) begin : g_core
    assign bank_sel[c] = BANK_IW'((core_addr_i[c] >> 2) % N_BANK); // word interleaved
    assign core_payload[c] = {
      core_wen_i[c],
      core_addr_i[c][tcdm_pkg::TS_BIT] & ~core_wen_i[c], // a write is never atomic
      core_addr_i[c][ROW_LSB +: ROW_W],
      core_be_i[c],
      core_wdata_i[c]
    };

    // response exactly one cycle after every grant
    a_gnt_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
      core_gnt_o[c] |=> core_r_valid_o[c]);
  end

  for (genvar b = 0; b < N_BANK; b++) begin : g_bank
    for (genvar c = 0; c < N_CORE; c++) begin : g_req
      assign bank_core_req[b][c] = core_req_i[c] && (bank_sel[c] == BANK_IW'(b));
    end

    bank_arbiter #(
      .N_CORE    ( N_CORE        ),
      .payload_t ( req_payload_t )
    ) i_arb (
      .clk_i      ( clk_i            ),
      .rst_ni     ( rst_ni           ),
      .policy_i   ( policy_i         ),
      .req_i      ( bank_core_req[b] ),
      .payload_i  ( core_payload     ),
      .gnt_o      ( bank_gnt[b]      ),
      .valid_o    ( bank_req_o[b]    ),
      .winner_o   ( bank_winner[b]   ),
      .payload_o  ( bank_payload[b]  ),
      .conflict_o ( conflict_o[b]    )
    );

    assign {bank_wen_o[b], bank_ts_o[b], bank_row_o[b], bank_be_o[b], bank_wdata_o[b]}
      = bank_payload[b];
  end

  always_comb begin : gnt_merge
    core_gnt_o = '0;
    for (int b = 0; b < N_BANK; b++) core_gnt_o |= bank_gnt[b];
  end

  // bank never stalls, so every bank request is a grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= '0;
      resp_core_q  <= '0;
    end else begin
      resp_valid_q <= bank_req_o;
      resp_core_q  <= bank_winner;
    end
  end

  always_comb begin : resp_route
    core_r_valid_o = '0;
    core_r_rdata_o = '0;
    for (int b = 0; b < N_BANK; b++) begin
      if (resp_valid_q[b]) begin
        core_r_valid_o[resp_core_q[b]] = 1'b1;
        core_r_rdata_o[resp_core_q[b]] = bank_rdata_i[b]; // one bank per core at most
      end
    end
  end

endmodule

`default_nettype wire

//--- source/tcdm_bank.sv
/*
 * sram bank
 * single-cycle word memory with byte enables, registered read data
 * and a test-and-set that returns the old word and writes all ones
 */

`timescale 1ns/1ps
`default_nettype none

module tcdm_bank #(
  parameter int unsigned BANK_WORDS = 64,
  localparam int unsigned ROW_W     = $clog2(BANK_WORDS)
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         req_i,
  input  logic                         wen_i,   // 1 is a write
  input  logic                         ts_i,
  input  logic [ROW_W-1:0]             row_i,
  input  logic [tcdm_pkg::BE_W-1:0]    be_i,
  input  logic [tcdm_pkg::DATA_W-1:0]  wdata_i,
  output logic [tcdm_pkg::DATA_W-1:0]  rdata_o
);

  logic [tcdm_pkg::DATA_W-1:0] mem_q [BANK_WORDS];

  always_ff @(posedge clk_i) begin : mem_write
    if (req_i && wen_i) begin
      for (int i = 0; i < tcdm_pkg::BE_W; i++) begin
        if (be_i[i]) mem_q[row_i][8*i +: 8] <= wdata_i[8*i +: 8];
      end
    end else if (req_i && ts_i) begin
      mem_q[row_i] <= '1; // lock value, old word still read below
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : mem_read
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i && !wen_i) begin
      rdata_o <= mem_q[row_i];
    end
  end

  a_ts_not_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && ts_i |-> !wen_i);

endmodule

`default_nettype wire

//--- source/tcdm_subsystem.sv
/*
 * tcdm subsystem
 * top level joining the arbitration control, the logarithmic
 * crossbar and the word-interleaved sram banks
 */

`timescale 1ns/1ps
`default_nettype none

module tcdm_subsystem #(
  parameter int unsigned N_CORE     = 4,
  parameter int unsigned N_BANK     = 4,
  parameter int unsigned BANK_WORDS = 64
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // core side
  input  logic [N_CORE-1:0]                        core_req_i,
  input  logic [N_CORE-1:0]                        core_wen_i,
  input  logic [N_CORE-1:0][tcdm_pkg::ADDR_W-1:0]  core_addr_i,
  input  logic [N_CORE-1:0][tcdm_pkg::BE_W-1:0]    core_be_i,
  input  logic [N_CORE-1:0][tcdm_pkg::DATA_W-1:0]  core_wdata_i,
  output logic [N_CORE-1:0]                        core_gnt_o,
  output logic [N_CORE-1:0]                        core_r_valid_o,
  output logic [N_CORE-1:0][tcdm_pkg::DATA_W-1:0]  core_r_rdata_o,
  // configuration
  input  logic                                     cfg_we_i,
  input  tcdm_pkg::policy_t                        cfg_policy_i,
  output tcdm_pkg::policy_t                        policy_o,
  output logic [15:0]                              conflict_cnt_o
);

  localparam int unsigned ROW_W = $clog2(BANK_WORDS);

  tcdm_pkg::policy_t                         policy;
  logic [N_BANK-1:0]                         conflict;
  logic [N_BANK-1:0]                         bank_req;
  logic [N_BANK-1:0]                         bank_wen;
  logic [N_BANK-1:0]                         bank_ts;
  logic [N_BANK-1:0][ROW_W-1:0]              bank_row;
  logic [N_BANK-1:0][tcdm_pkg::BE_W-1:0]     bank_be;
  logic [N_BANK-1:0][tcdm_pkg::DATA_W-1:0]   bank_wdata;
  logic [N_BANK-1:0][tcdm_pkg::DATA_W-1:0]   bank_rdata;

  assign policy_o = policy;

  tcdm_arb_ctrl #(
    .N_BANK ( N_BANK )
  ) i_arb_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .cfg_we_i       ( cfg_we_i       ),
    .cfg_policy_i   ( cfg_policy_i   ),
    .conflict_i     ( conflict       ),
    .policy_o       ( policy         ),
    .conflict_cnt_o ( conflict_cnt_o )
  );

  tcdm_xbar #(
    .N_CORE     ( N_CORE     ),
    .N_BANK     ( N_BANK     ),
    .BANK_WORDS ( BANK_WORDS )
  ) i_xbar (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .policy_i       ( policy         ),
    .conflict_o     ( conflict       ),
    .core_req_i     ( core_req_i     ),
    .core_wen_i     ( core_wen_i     ),
    .core_addr_i    ( core_addr_i    ),
    .core_be_i      ( core_be_i      ),
    .core_wdata_i   ( core_wdata_i   ),
    .core_gnt_o     ( core_gnt_o     ),
    .core_r_valid_o ( core_r_valid_o ),
    .core_r_rdata_o ( core_r_rdata_o ),
    .bank_req_o     ( bank_req       ),
    .bank_wen_o     ( bank_wen       ),
    .bank_ts_o      ( bank_ts        ),
    .bank_row_o     ( bank_row       ),
    .bank_be_o      ( bank_be        ),
    .bank_wdata_o   ( bank_wdata     ),
    .bank_rdata_i   ( bank_rdata     )
  );

  for (genvar b = 0; b < N_BANK; b++) begin : g_bank
    tcdm_bank #(
      .BANK_WORDS ( BANK_WORDS )
    ) i_bank (
      .clk_i   ( clk_i         ),
      .rst_ni  ( rst_ni        ),
      .req_i   ( bank_req[b]   ),
      .wen_i   ( bank_wen[b]   ),
      .ts_i    ( bank_ts[b]    ),
      .row_i   ( bank_row[b]   ),
      .be_i    ( bank_be[b]    ),
      .wdata_i ( bank_wdata[b] ),
      .rdata_o ( bank_rdata[b] )
    );
  end

endmodule

`default_nettype wire

//--- sim/tb_tcdm.sv
/*
 * tcdm subsystem testbench
 * replays per-cycle core requests from a stimulus file and checks
 * grants, responses, the arbitration policy and the conflict counter
 */

`timescale 1ns/1ps
`default_nettype none

module tb_tcdm;

  localparam int unsigned N_CORE     = 4;
  localparam int unsigned N_BANK     = 4;
  localparam int unsigned BANK_WORDS = 64;
  localparam int unsigned AW         = tcdm_pkg::ADDR_W;
  localparam int unsigned DW         = tcdm_pkg::DATA_W;
  localparam int unsigned BW         = tcdm_pkg::BE_W;
  localparam int unsigned MAX_REC    = 64;
  localparam int unsigned REC_FIELDS = 4 + 7 * N_CORE; // cfg part, then seven per core

  logic                      clk_i;
  logic                      rst_ni;
  logic [N_CORE-1:0]         core_req_i;
  logic [N_CORE-1:0]         core_wen_i;
  logic [N_CORE-1:0][AW-1:0] core_addr_i;
  logic [N_CORE-1:0][BW-1:0] core_be_i;
  logic [N_CORE-1:0][DW-1:0] core_wdata_i;
  logic [N_CORE-1:0]         core_gnt_o;
  logic [N_CORE-1:0]         core_r_valid_o;
  logic [N_CORE-1:0][DW-1:0] core_r_rdata_o;
  logic                      cfg_we_i;
  tcdm_pkg::policy_t         cfg_policy_i;
  tcdm_pkg::policy_t         policy_o;
  logic [15:0]               conflict_cnt_o;

  // one record per cycle, loaded before reset is released
  logic                      cfg_we_m  [MAX_REC];
  logic                      cfg_pol_m [MAX_REC];
  logic                      pol_exp_m [MAX_REC];
  logic [15:0]               cnt_exp_m [MAX_REC];
  logic [N_CORE-1:0]         req_m     [MAX_REC];
  logic [N_CORE-1:0]         wen_m     [MAX_REC];
  logic [N_CORE-1:0]         gnt_m     [MAX_REC];
  logic [N_CORE-1:0]         rdc_m     [MAX_REC]; // rdata not checked
  logic [N_CORE-1:0][AW-1:0] addr_m    [MAX_REC];
  logic [N_CORE-1:0][BW-1:0] be_m      [MAX_REC];
  logic [N_CORE-1:0][DW-1:0] wdata_m   [MAX_REC];
  logic [N_CORE-1:0][DW-1:0] rdata_m   [MAX_REC];

  int fd;
  int n_rec;
  int n_errors;
  int limit_ns;

  tcdm_subsystem #(
    .N_CORE     ( N_CORE     ),
    .N_BANK     ( N_BANK     ),
    .BANK_WORDS ( BANK_WORDS )
  ) dut (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .core_req_i     ( core_req_i     ),
    .core_wen_i     ( core_wen_i     ),
    .core_addr_i    ( core_addr_i    ),
    .core_be_i      ( core_be_i      ),
    .core_wdata_i   ( core_wdata_i   ),
    .core_gnt_o     ( core_gnt_o     ),
    .core_r_valid_o ( core_r_valid_o ),
    .core_r_rdata_o ( core_r_rdata_o ),
    .cfg_we_i       ( cfg_we_i       ),
    .cfg_policy_i   ( cfg_policy_i   ),
    .policy_o       ( policy_o       ),
    .conflict_cnt_o ( conflict_cnt_o )
  );

  always #10 clk_i = ~clk_i; // 20 ns period

  // next token of the stimulus file, comment lines skipped
  task automatic read_field(output logic [31:0] val, output logic dc, output logic ok);
    string tok;
    string rest;
    int    n;
    logic  done;
    val  = '0;
    dc   = 1'b0;
    ok   = 1'b0;
    done = 1'b0;
    while (!done) begin
      n = $fscanf(fd, "%s", tok);
      if (n != 1) begin
        done = 1'b1; // end of file
      end else if (tok.getc(0) == "#") begin
        n = $fgets(rest, fd);
      end else begin
        ok   = 1'b1;
        done = 1'b1;
        if (tok == "-") dc = 1'b1;
        else n = $sscanf(tok, "%h", val);
      end
    end
  endtask

  task automatic load_stimulus();
    logic [31:0] f   [REC_FIELDS];
    logic        fdc [REC_FIELDS];
    logic        ok;
    logic        more;
    int          got;
    int          base;
    n_rec = 0;
    more  = 1'b1;
    fd = $fopen("sim/tcdm_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file sim/tcdm_stimulus.txt");
      n_errors++;
      more = 1'b0;
    end
    while (more) begin
      got = 0;
      for (int i = 0; i < REC_FIELDS; i++) begin
        read_field(f[i], fdc[i], ok);
        if (ok) got++;
      end
      if (got == 0) begin
        more = 1'b0;
      end else if (got < REC_FIELDS || n_rec >= MAX_REC) begin
        $display("stimulus file is malformed at record %0d", n_rec);
        n_errors++;
        more = 1'b0;
      end else begin
        cfg_we_m[n_rec]  = f[0][0];
        cfg_pol_m[n_rec] = f[1][0];
        pol_exp_m[n_rec] = f[2][0];
        cnt_exp_m[n_rec] = f[3][15:0];
        for (int c = 0; c < N_CORE; c++) begin
          base = 4 + 7 * c;
          req_m[n_rec][c]   = f[base][0];
          wen_m[n_rec][c]   = f[base+1][0];
          addr_m[n_rec][c]  = f[base+2][AW-1:0];
          be_m[n_rec][c]    = f[base+3][BW-1:0];
          wdata_m[n_rec][c] = f[base+4];
          gnt_m[n_rec][c]   = f[base+5][0];
          rdata_m[n_rec][c] = f[base+6];
          rdc_m[n_rec][c]   = fdc[base+6];
        end
        n_rec++;
      end
    end
    if (fd != 0) $fclose(fd);
    if (n_rec == 0) begin
      $display("stimulus file holds no records");
      n_errors++;
    end
  endtask

  task automatic drive_record(input int k);
    cfg_we_i     <= cfg_we_m[k];
    cfg_policy_i <= tcdm_pkg::policy_t'(cfg_pol_m[k]);
    core_req_i   <= req_m[k];
    core_wen_i   <= wen_m[k];
    core_addr_i  <= addr_m[k];
    core_be_i    <= be_m[k];
    core_wdata_i <= wdata_m[k];
  endtask

  task automatic drive_idle();
    cfg_we_i   <= 1'b0;
    core_req_i <= '0;
    core_wen_i <= '0;
  endtask

  // grants, policy and counter seen in the cycle of record k
  task automatic check_request(input int k);
    if (core_gnt_o !== gnt_m[k]) begin
      $display("FAIL rec %0d core_gnt_o got %h expected %h", k, core_gnt_o, gnt_m[k]);
      n_errors++;
    end
    if (policy_o !== tcdm_pkg::policy_t'(pol_exp_m[k])) begin
      $display("FAIL rec %0d policy_o got %h expected %h", k, policy_o, pol_exp_m[k]);
      n_errors++;
    end
    if (conflict_cnt_o !== cnt_exp_m[k]) begin
      $display("FAIL rec %0d conflict_cnt_o got %h expected %h", k, conflict_cnt_o,
               cnt_exp_m[k]);
      n_errors++;
    end
  endtask

  // responses to the grants of record k, one cycle later
  task automatic check_response(input int k);
    for (int c = 0; c < N_CORE; c++) begin
      if (core_r_valid_o[c] !== gnt_m[k][c]) begin
        $display("FAIL rec %0d core_r_valid_o[%0d] got %h expected %h", k, c,
                 core_r_valid_o[c], gnt_m[k][c]);
        n_errors++;
      end
      if (gnt_m[k][c] && !rdc_m[k][c] && core_r_rdata_o[c] !== rdata_m[k][c]) begin
        $display("FAIL rec %0d core_r_rdata_o[%0d] got %h expected %h", k, c,
                 core_r_rdata_o[c], rdata_m[k][c]);
        n_errors++;
      end
    end
  endtask

  initial begin : watchdog
    wait (limit_ns > 0);
    #(limit_ns);
    $display("timeout, the run did not end within %0d ns", limit_ns);
    $display("tests failed");
    $finish;
  end

  initial begin : main
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    core_req_i   = '0;
    core_wen_i   = '0;
    core_addr_i  = '0;
    core_be_i    = '0;
    core_wdata_i = '0;
    cfg_we_i     = 1'b0;
    cfg_policy_i = tcdm_pkg::POLICY_FIXED;
    n_errors     = 0;
    load_stimulus();
    limit_ns = (8 + n_rec + 12) * 20; // reset, records, trailing cycle and margin
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    if (core_r_valid_o !== '0) begin
      $display("FAIL reset core_r_valid_o got %h expected %h", core_r_valid_o, 4'h0);
      n_errors++;
    end
    if (policy_o !== tcdm_pkg::POLICY_FIXED) begin
      $display("FAIL reset policy_o got %h expected %h", policy_o, tcdm_pkg::POLICY_FIXED);
      n_errors++;
    end
    if (conflict_cnt_o !== 16'h0) begin
      $display("FAIL reset conflict_cnt_o got %h expected %h", conflict_cnt_o, 16'h0);
      n_errors++;
    end
    for (int k = 0; k <= n_rec; k++) begin
      @(posedge clk_i);
      if (k < n_rec) drive_record(k);
      else drive_idle(); // one extra cycle for the last responses
      @(negedge clk_i);
      if (k < n_rec) check_request(k);
      if (k > 0) check_response(k - 1);
    end
    $display("records %0d errors %0d", n_rec, n_errors);
    if (n_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/tcdm_stimulus.txt
# per cycle: cfg_we cfg_policy exp_policy exp_conflict_cnt, then for cores 0..3 in turn:
# req wen addr be wdata exp_gnt exp_rdata (rdata due one cycle later, - is don't care)
# four writes to four banks, no conflict
0 0 0 0  1 1 010 f 11111111 1 -         1 1 014 f 22222222 1 -
         1 1 018 f 33333333 1 -         1 1 01c f 44444444 1 -
0 0 0 0  1 0 014 f 00000000 1 22222222  1 0 018 f 00000000 1 33333333
         1 0 01c f 00000000 1 44444444  1 0 010 f 00000000 1 11111111
# byte enables merge with the old word
0 0 0 0  1 1 010 5 aabbccdd 1 -         0 0 000 0 00000000 0 -
         0 0 000 0 00000000 0 -         0 0 000 0 00000000 0 -
0 0 0 0  1 0 010 f 00000000 1 11bb11dd  1 1 014 8 99887766 1 -
         0 0 000 0 00000000 0 -         0 0 000 0 00000000 0 -
# fixed priority, all cores on bank 1
0 0 0 0  1 0 014 f 00000000 1 99222222  1 0 014 f 00000000 0 -
         1 0 014 f 00000000 0 -         1 0 014 f 00000000 0 -
0 0 0 1  0 0 000 0 00000000 0 -         1 0 014 f 00000000 1 99222222
         1 0 014 f 00000000 0 -         1 0 014 f 00000000 0 -
0 0 0 2  0 0 000 0 00000000 0 -         0 0 000 0 00000000 0 -
         1 0 014 f 00000000 1 99222222  1 0 014 f 00000000 0 -
1 1 0 3  0 0 000 0 00000000 0 -         0 0 000 0 00000000 0 -
         0 0 000 0 00000000 0 -         1 0 014 f 00000000 1 99222222
# round robin on bank 2, last winner core 1
0 0 1 3  1 0 018 f 00000000 0 -         1 0 018 f 00000000 0 -
         1 0 018 f 00000000 1 33333333  1 0 018 f 00000000 0 -
0 0 1 4  1 0 018 f 00000000 0 -         1 0 018 f 00000000 0 -
         0 0 000 0 00000000 0 -         1 0 018 f 00000000 1 33333333
0 0 1 5  1 0 018 f 00000000 1 33333333  1 0 018 f 00000000 0 -
         0 0 000 0 00000000 0 -         0 0 000 0 00000000 0 -
0 0 1 6  0 0 000 0 00000000 0 -         1 0 018 f 00000000 1 33333333
         0 0 000 0 00000000 0 -         0 0 000 0 00000000 0 -
# round robin on bank 3, last winner core 2
0 0 1 6  1 0 01c f 00000000 0 -         1 0 01c f 00000000 0 -
         1 0 01c f 00000000 0 -         1 0 01c f 00000000 1 44444444
0 0 1 7  1 0 01c f 00000000 1 44444444  1 0 01c f 00000000 0 -
         1 0 01c f 00000000 0 -         0 0 000 0 00000000 0 -
0 0 1 8  0 0 000 0 00000000 0 -         1 0 01c f 00000000 1 44444444
         1 0 01c f 00000000 0 -         0 0 000 0 00000000 0 -
0 0 1 9  0 0 000 0 00000000 0 -         0 0 000 0 00000000 0 -
         1 0 01c f 00000000 1 44444444  0 0 000 0 00000000 0 -
# test-and-set on bank 0 row 2
0 0 1 9  0 0 000 0 00000000 0 -         1 1 020 f 5a5a0001 1 -
         0 0 000 0 00000000 0 -         0 0 000 0 00000000 0 -
0 0 1 9  0 0 000 0 00000000 0 -         1 0 420 f 00000000 1 5a5a0001
         0 0 000 0 00000000 0 -         0 0 000 0 00000000 0 -
0 0 1 9  0 0 000 0 00000000 0 -         1 0 420 f 00000000 1 ffffffff
         0 0 000 0 00000000 0 -         0 0 000 0 00000000 0 -
0 0 1 9  0 0 000 0 00000000 0 -         0 0 000 0 00000000 0 -
         1 0 020 f 00000000 1 ffffffff  0 0 000 0 00000000 0 -

//--- verilog.f
source/tcdm_pkg.sv
source/tcdm_arb_ctrl.sv
source/bank_arbiter.sv
source/tcdm_xbar.sv
source/tcdm_bank.sv
source/tcdm_subsystem.sv
sim/tb_tcdm.sv

//--- Makefile
# verilator build, run, lint and clean for the tcdm subsystem

all: run

obj_dir/Vtb_tcdm: verilog.f source/*.sv sim/tb_tcdm.sv
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_tcdm

run: obj_dir/Vtb_tcdm
	@out="$$(./obj_dir/Vtb_tcdm)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module tcdm_subsystem

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
